//--- Makefile
# verilator build and run of the triangle generator testbench
TOP = tri_gen_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

# pass only when the log holds the pass message
run: compile
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+tb
hw/tri_pkg.sv
hw/tri_step_table.sv
hw/tri_phase_accum.sv
hw/tri_shaper.sv
hw/tri_trigger.sv
hw/tri_gen_top.sv
tb/tri_gen_tb.sv

//--- hw/tri_gen_top.sv
// triangle generator top level
// step table, phase accumulator, shaper and trigger behind plain ports
`timescale 1ns/1ps
module tri_gen_top (
  input  logic                                             dac_clk,
  input  logic                                             dac_reset,
  input  logic [tri_pkg::channels*tri_pkg::phase_bits-1:0] phase_inc,
  input  logic                                             phase_inc_load,
  output tri_pkg::dac_batch_t                              dac_data,
  output logic                                             dac_valid,
  output tri_pkg::trigger_t                                dac_trigger
);

  tri_pkg::step_table_t  steps;
  tri_pkg::batch_phase_t sample_phase;
  logic                  valid;

  // matches the two stage shaper latency
  logic [1:0] valid_pipe;

  tri_step_table u_step_table (
    .dac_clk        (dac_clk),
    .dac_reset      (dac_reset),
    .phase_inc      (phase_inc),
    .phase_inc_load (phase_inc_load),
    .steps          (steps)
  );

  tri_phase_accum u_phase_accum (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .steps        (steps),
    .sample_phase (sample_phase),
    .valid        (valid)
  );

  tri_shaper u_shaper (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .sample_phase (sample_phase),
    .dac_data     (dac_data)
  );

  tri_trigger u_trigger (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .sample_phase (sample_phase),
    .dac_trigger  (dac_trigger)
  );

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[0], valid};
    end
  end

  assign dac_valid = valid_pipe[1];

endmodule

//--- hw/tri_phase_accum.sv
// triangle phase accumulator
// advances one cycle phase per channel and fans it out into a batch of sample phases
`timescale 1ns/1ps
module tri_phase_accum (
  input  logic                  dac_clk,
  input  logic                  dac_reset,
  input  tri_pkg::step_table_t  steps,
  output tri_pkg::batch_phase_t sample_phase,
  output logic                  valid
);

  // phase of sample 0 of the next batch, per channel
  tri_pkg::phase_word_t [tri_pkg::channels-1:0] cycle_phase;

  // fills with ones after reset, two edges to reach the top
  logic [1:0] valid_sr;

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      cycle_phase  <= '0;
      sample_phase <= '0;
    end else begin
      for (int ch = 0; ch < tri_pkg::channels; ch++) begin
        // a whole batch worth of phase each clock
        cycle_phase[ch] <= cycle_phase[ch] + steps[ch][tri_pkg::parallel_samples-1];
        // first sample is the cycle phase itself
        sample_phase[ch][0].raw <= cycle_phase[ch];
        // the others are offset by 1..n-1 increments
        for (int s = 1; s < tri_pkg::parallel_samples; s++) begin
          sample_phase[ch][s].raw <= cycle_phase[ch] + steps[ch][s-1];
        end
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[0], 1'b1};
    end
  end

  assign valid = valid_sr[1];

  // batches run continuously, so valid never drops outside reset
  a_valid_sticky : assert property (
    @(posedge dac_clk) disable iff (dac_reset) valid |=> valid
  ) else $error("valid dropped without reset");

endmodule

//--- hw/tri_pkg.sv
// triangle generator package
// sizes, the phase word union and the batch, sample and trigger types
package tri_pkg;

  // number of independent waveform channels
  localparam int channels = 2;
  // dac samples per channel delivered each clock
  localparam int parallel_samples = 4;
  // phase accumulator resolution
  localparam int phase_bits = 24;
  // width of one dac sample
  localparam int sample_width = 16;

  // raw unsigned phase, used for accumulation and step multiples
  typedef logic [phase_bits-1:0] phase_word_t;

  // phase split for shaping and triggering
  // half = 0 is the rising half of the wave
  typedef struct packed {
    logic                  half;
    logic                  quarter;
    logic [phase_bits-3:0] frac;
  } phase_fields_t;

  // one phase word, read either as a number or as fields
  typedef union packed {
    phase_word_t   raw;
    phase_fields_t fields;
  } phase_word_u;

  // sample phases of one batch, per channel and sample
  typedef phase_word_u [channels-1:0][parallel_samples-1:0] batch_phase_t;

  // increment times 1..parallel_samples for each channel
  typedef phase_word_t [channels-1:0][parallel_samples-1:0] step_table_t;

  // per channel word, sample 0 sits in the low bits
  typedef logic [channels-1:0][parallel_samples*sample_width-1:0] dac_batch_t;

  // one trigger bit per channel
  typedef logic [channels-1:0] trigger_t;

endpackage

//--- hw/tri_shaper.sv
// triangle shaper
// folds every sample phase into a triangle value and truncates it to the dac width
`timescale 1ns/1ps
module tri_shaper (
  input  logic                  dac_clk,
  input  logic                  dac_reset,
  input  tri_pkg::batch_phase_t sample_phase,
  output tri_pkg::dac_batch_t   dac_data
);

  // full precision triangle, first pipeline stage
  tri_pkg::phase_word_t [tri_pkg::channels-1:0][tri_pkg::parallel_samples-1:0] tri_full;

  // twice the low phase bits, i.e. the slope term
  tri_pkg::phase_word_t [tri_pkg::channels-1:0][tri_pkg::parallel_samples-1:0] slope;

  always_comb begin
    for (int ch = 0; ch < tri_pkg::channels; ch++) begin
      for (int s = 0; s < tri_pkg::parallel_samples; s++) begin
        // quarter and frac together are the low phase_bits-1 bits
        slope[ch][s] = {sample_phase[ch][s].fields.quarter,
                        sample_phase[ch][s].fields.frac, 1'b0};
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      tri_full <= '0;
    end else begin
      for (int ch = 0; ch < tri_pkg::channels; ch++) begin
        for (int s = 0; s < tri_pkg::parallel_samples; s++) begin
          if (!sample_phase[ch][s].fields.half) begin
            // rising half, count up from the midpoint
            tri_full[ch][s] <= {1'b1, {(tri_pkg::phase_bits-1){1'b0}}} + slope[ch][s];
          end else begin
            // falling half, count down from just below the midpoint
            tri_full[ch][s] <= {1'b0, {(tri_pkg::phase_bits-1){1'b1}}} - slope[ch][s];
          end
        end
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      dac_data <= '0;
    end else begin
      for (int ch = 0; ch < tri_pkg::channels; ch++) begin
        for (int s = 0; s < tri_pkg::parallel_samples; s++) begin
          // keep the msbs, sample s lands in lane s
          dac_data[ch][s*tri_pkg::sample_width +: tri_pkg::sample_width] <=
            tri_full[ch][s][tri_pkg::phase_bits-1 -: tri_pkg::sample_width];
        end
      end
    end
  end

endmodule

//--- hw/tri_step_table.sv
// triangle step table
// holds the per-sample phase step multiples of every channel
`timescale 1ns/1ps
module tri_step_table (
  input  logic                                         dac_clk,
  input  logic                                         dac_reset,
  input  logic [tri_pkg::channels*tri_pkg::phase_bits-1:0] phase_inc,
  input  logic                                         phase_inc_load,
  output tri_pkg::step_table_t                         steps
);

  // increment of each channel sliced out of the packed input
  tri_pkg::phase_word_t inc_word [tri_pkg::channels];

  always_comb begin
    for (int ch = 0; ch < tri_pkg::channels; ch++) begin
      // channel 0 in the low bits
      inc_word[ch] = phase_inc[ch*tri_pkg::phase_bits +: tri_pkg::phase_bits];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      steps <= '0;
    end else if (phase_inc_load) begin
      for (int ch = 0; ch < tri_pkg::channels; ch++) begin
        for (int s = 0; s < tri_pkg::parallel_samples; s++) begin
          // entry s holds inc * (s+1), wraps modulo the phase range
          // last entry doubles as the per-clock advance
          steps[ch][s] <= inc_word[ch] * tri_pkg::phase_word_t'(s + 1);
        end
      end
    end
    // no load: keep the old steps so the phase runs on undisturbed
  end

endmodule

//--- hw/tri_trigger.sv
// triangle trigger
// pulses when a channel passes upward through its midpoint in step with the data
`timescale 1ns/1ps
module tri_trigger (
  input  logic                  dac_clk,
  input  logic                  dac_reset,
  input  tri_pkg::batch_phase_t sample_phase,
  output tri_pkg::trigger_t     dac_trigger
);

  // half and quarter bits gathered per channel
  logic [tri_pkg::channels-1:0][tri_pkg::parallel_samples-1:0] half_bits;
  logic [tri_pkg::channels-1:0][tri_pkg::parallel_samples-1:0] quarter_bits;

  // first stage conditions
  tri_pkg::trigger_t rising_half;
  tri_pkg::trigger_t cross_in_batch;
  tri_pkg::trigger_t cross_between;
  // previous batch had every quarter bit low
  tri_pkg::trigger_t quarter_low_d;

  always_comb begin
    for (int ch = 0; ch < tri_pkg::channels; ch++) begin
      for (int s = 0; s < tri_pkg::parallel_samples; s++) begin
        half_bits[ch][s]    = sample_phase[ch][s].fields.half;
        quarter_bits[ch][s] = sample_phase[ch][s].fields.quarter;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      rising_half    <= '0;
      cross_in_batch <= '0;
      cross_between  <= '0;
      quarter_low_d  <= '0;
    end else begin
      for (int ch = 0; ch < tri_pkg::channels; ch++) begin
        // whole batch sits in the rising half
        rising_half[ch]    <= ~(|half_bits[ch]);
        // some samples before the midpoint, some after
        cross_in_batch[ch] <= (|quarter_bits[ch]) & ~(&quarter_bits[ch]);
        // midpoint fell exactly on the batch boundary
        cross_between[ch]  <= (&quarter_bits[ch]) & quarter_low_d[ch];
        quarter_low_d[ch]  <= ~(|quarter_bits[ch]);
      end
    end
  end

  // second stage lines up with dac_data
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      dac_trigger <= '0;
    end else begin
      dac_trigger <= rising_half & (cross_in_batch | cross_between);
    end
  end

  // first output after reset release comes from the cleared first stage
  a_trig_reset : assert property (
    @(posedge dac_clk) $fell(dac_reset) |=> (dac_trigger == '0)
  ) else $error("trigger set in the cycle after reset");

endmodule

//--- tb/tri_model.svh
// triangle generator reference model
// tracks steps, phases, the triangle fold and the midpoint trigger one clock at a time
`ifndef TRI_MODEL_SVH
`define TRI_MODEL_SVH

tri_pkg::phase_word_t m_steps [tri_pkg::channels][tri_pkg::parallel_samples];
tri_pkg::phase_word_t m_cycle [tri_pkg::channels];
tri_pkg::phase_word_t m_phase [tri_pkg::channels][tri_pkg::parallel_samples];
// full precision triangle, one stage ahead of the data
tri_pkg::phase_word_t m_tri [tri_pkg::channels][tri_pkg::parallel_samples];
tri_pkg::dac_batch_t  m_data;
// first trigger stage
tri_pkg::trigger_t    m_up;
tri_pkg::trigger_t    m_inside;
tri_pkg::trigger_t    m_between;
tri_pkg::trigger_t    m_was_low;
// expected trigger output
tri_pkg::trigger_t    m_trig;
// rising edges since reset was released, saturates at 4
int                   m_edges;
// how many expected triggers came from each kind of crossing
int                   seen_inside;
int                   seen_between;

// rising half climbs from the midpoint, falling half mirrors it just below
function automatic tri_pkg::phase_word_t fold_phase(input tri_pkg::phase_word_t p);
  tri_pkg::phase_word_t mid;
  tri_pkg::phase_word_t ramp;
  mid  = tri_pkg::phase_word_t'(1) << (tri_pkg::phase_bits - 1);
  ramp = (p & (mid - tri_pkg::phase_word_t'(1))) << 1;
  return (p < mid) ? mid + ramp : mid - tri_pkg::phase_word_t'(1) - ramp;
endfunction

task automatic model_step();
  tri_pkg::phase_word_t inc;
  tri_pkg::phase_word_t acc;
  int low_half;
  int quarter;
  if (dac_reset) begin
    m_steps   = '{default: '0};
    m_cycle   = '{default: '0};
    m_phase   = '{default: '0};
    m_tri     = '{default: '0};
    m_data    = '0;
    m_up      = '0;
    m_inside  = '0;
    m_between = '0;
    m_was_low = '0;
    m_trig    = '0;
    m_edges   = 0;
  end else begin
    // output end first, so every stage reads what it held before this edge
    m_trig = m_up & (m_inside | m_between);
    seen_inside  += $countones(m_trig & m_inside);
    seen_between += $countones(m_trig & m_between);
    for (int ch = 0; ch < tri_pkg::channels; ch++) begin
      low_half = 0;
      quarter  = 0;
      for (int s = 0; s < tri_pkg::parallel_samples; s++) begin
        if (!m_phase[ch][s][tri_pkg::phase_bits-1]) low_half++;
        if (m_phase[ch][s][tri_pkg::phase_bits-2]) quarter++;
        // top bits of the folded value become the sample
        m_data[ch][s*tri_pkg::sample_width +: tri_pkg::sample_width] =
          m_tri[ch][s][tri_pkg::phase_bits-1 -: tri_pkg::sample_width];
        m_tri[ch][s] = fold_phase(m_phase[ch][s]);
      end
      m_up[ch]      = (low_half == tri_pkg::parallel_samples);
      m_inside[ch]  = (quarter > 0) && (quarter < tri_pkg::parallel_samples);
      m_between[ch] = (quarter == tri_pkg::parallel_samples) && m_was_low[ch];
      m_was_low[ch] = (quarter == 0);
      // sample s sits s increments past the cycle phase
      m_phase[ch][0] = m_cycle[ch];
      for (int s = 1; s < tri_pkg::parallel_samples; s++) begin
        m_phase[ch][s] = m_cycle[ch] + m_steps[ch][s-1];
      end
      m_cycle[ch] = m_cycle[ch] + m_steps[ch][tri_pkg::parallel_samples-1];
      if (phase_inc_load) begin
        inc = phase_inc[ch*tri_pkg::phase_bits +: tri_pkg::phase_bits];
        acc = '0;
        // multiples built by repeated addition
        for (int s = 0; s < tri_pkg::parallel_samples; s++) begin
          acc = acc + inc;
          m_steps[ch][s] = acc;
        end
      end
    end
    if (m_edges < 4) m_edges++;
  end
endtask

`endif

//--- tb/tri_gen_tb.sv
// triangle generator testbench
// seeded random increments, every output compared each cycle with a reference model
`timescale 1ns/1ps
module tri_gen_tb;

  logic                                             dac_clk;
  logic                                             dac_reset;
  logic [tri_pkg::channels*tri_pkg::phase_bits-1:0] phase_inc;
  logic                                             phase_inc_load;
  tri_pkg::dac_batch_t                              dac_data;
  logic                                             dac_valid;
  tri_pkg::trigger_t                                dac_trigger;

  `include "tri_model.svh"

  tri_gen_top DUT (
    .dac_clk        (dac_clk),
    .dac_reset      (dac_reset),
    .phase_inc      (phase_inc),
    .phase_inc_load (phase_inc_load),
    .dac_data       (dac_data),
    .dac_valid      (dac_valid),
    .dac_trigger    (dac_trigger)
  );

  initial begin
    dac_clk = 1'b0;
    forever #10 dac_clk = ~dac_clk;
  end

  // model sees the same inputs as the DUT at each edge
  always @(posedge dac_clk) model_step();

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_batch(input tri_pkg::dac_batch_t expected, input tri_pkg::dac_batch_t actual);
    if (actual !== expected) begin
      $display("FAIL time=%0t dac_data expected=%h actual=%h", $time, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_trigger(input tri_pkg::trigger_t expected, input tri_pkg::trigger_t actual);
    if (actual !== expected) begin
      $display("FAIL time=%0t dac_trigger expected=%b actual=%b", $time, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_valid(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL time=%0t dac_valid expected=%b actual=%b", $time, expected, actual);
      abort_run();
    end
  endtask

  // outputs are settled at the falling edge
  initial begin
    @(posedge dac_clk);
    forever begin
      @(negedge dac_clk);
      check_valid(m_edges >= 4, dac_valid);
      check_batch(m_data, dac_data);
      check_trigger(m_trig, dac_trigger);
    end
  end

  task automatic wait_for_valid();
    int waited;
    waited = 0;
    while (dac_valid !== 1'b1) begin
      @(negedge dac_clk);
      waited++;
      if (waited > 16) begin
        $display("dac_valid did not rise after reset was released");
        abort_run();
      end
    end
  endtask

  task automatic load_increments(input logic [tri_pkg::channels*tri_pkg::phase_bits-1:0] incs);
    @(posedge dac_clk);
    phase_inc      <= incs;
    phase_inc_load <= 1'b1;
    @(posedge dac_clk);
    phase_inc_load <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge dac_clk);
  endtask

  // small increment, one draw in eight parks the channel
  function automatic tri_pkg::phase_word_t random_increment();
    if ($urandom_range(7, 0) == 0) return '0;
    return tri_pkg::phase_word_t'($urandom_range(16383, 1));
  endfunction

  initial begin
    logic [tri_pkg::channels*tri_pkg::phase_bits-1:0] incs;
    void'($urandom(82));
    dac_reset      = 1'b1;
    phase_inc      = '0;
    phase_inc_load = 1'b0;
    repeat (10) @(posedge dac_clk);
    dac_reset <= 1'b0;
    wait_for_valid();
    // power of two step puts the ch0 midpoint on a batch boundary, ch1 parked
    incs = '0;
    incs[0 +: tri_pkg::phase_bits] = tri_pkg::phase_word_t'(4096);
    load_increments(incs);
    idle_cycles(1300);
    // random retunes in mid run
    for (int n = 0; n < 40; n++) begin
      for (int ch = 0; ch < tri_pkg::channels; ch++) begin
        incs[ch*tri_pkg::phase_bits +: tri_pkg::phase_bits] = random_increment();
      end
      load_increments(incs);
      idle_cycles($urandom_range(200, 20));
    end
    idle_cycles(8);
    if (seen_inside == 0 || seen_between == 0) begin
      $display("midpoint crossings were not seen both inside and between batches");
      abort_run();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
